// File: Makefile
# Verilator flow for the AXI4-Lite register subsystem

TB_TOP  := tb_axi4l_reg_subsys
RTL_TOP := axi4l_reg_subsys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(RTL_TOP)

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) 2>&1 | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/axi4l_controller.sv
`include "axi4l_params.svh"

module axi4l_controller #(
    parameter int WR_TIMEOUT = `AXI4L_WR_TIMEOUT,
    parameter int RD_TIMEOUT = `AXI4L_RD_TIMEOUT
) (
    input  logic                       clk,
    input  logic                       srst,
    input  logic                       wr,
    input  logic [`AXI4L_ADDR_WID-1:0] wr_addr,
    input  logic [`AXI4L_DATA_WID-1:0] wr_data,
    input  logic [`AXI4L_STRB_WID-1:0] wr_strb,
    output logic                       wr_ack,
    output axi4l_pkg::resp_t           wr_resp,
    input  logic                       rd,
    input  logic [`AXI4L_ADDR_WID-1:0] rd_addr,
    output logic [`AXI4L_DATA_WID-1:0] rd_data,
    output logic                       rd_ack,
    output axi4l_pkg::resp_t           rd_resp,
    output axi4l_pkg::axi4l_req_t      axi_req,
    input  axi4l_pkg::axi4l_rsp_t      axi_rsp
);
    import axi4l_pkg::*;

    // Room for several timed-out accesses still owed by the target
    localparam int STALE_WID = 4;

    logic                       awvalid;
    logic                       wvalid;
    logic [`AXI4L_ADDR_WID-1:0] awaddr;
    logic [`AXI4L_DATA_WID-1:0] wdata;
    logic [`AXI4L_STRB_WID-1:0] wstrb;
    logic                       wr_pending;
    logic                       wr_timeout;
    logic [STALE_WID-1:0]       wr_stale;
    logic                       bready;
    logic                       b_hs;
    logic                       b_live;
    logic                       wr_done;

    logic                       arvalid;
    logic [`AXI4L_ADDR_WID-1:0] araddr;
    logic                       rd_pending;
    logic                       rd_timeout;
    logic [STALE_WID-1:0]       rd_stale;
    logic                       rready;
    logic                       r_hs;
    logic                       r_live;
    logic                       rd_done;

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (wr) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            // Each channel drops on its own handshake
            if (axi_rsp.awready) awvalid <= 1'b0;
            if (axi_rsp.wready)  wvalid  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            awaddr <= wr_addr;
            wdata  <= wr_data;
            wstrb  <= wr_strb;
        end
    end

    // Keep draining late responses after a timeout
    assign bready  = wr_pending || (wr_stale != '0);
    assign b_hs    = bready && axi_rsp.bvalid;
    assign b_live  = b_hs && (wr_stale == '0);
    assign wr_done = wr_pending && (b_live || wr_timeout);

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_pending <= 1'b0;
            wr_stale   <= '0;
            wr_ack     <= 1'b0;
            wr_resp    <= RESP_OKAY;
        end else begin
            wr_ack <= wr_done;
            if (wr)
                wr_pending <= 1'b1;
            else if (wr_done)
                wr_pending <= 1'b0;
            wr_stale <= wr_stale + STALE_WID'(wr_timeout && !b_live)
                                 - STALE_WID'(b_hs && (wr_stale != '0));
            if (wr_done)
                wr_resp <= b_live ? axi_rsp.bresp : RESP_SLVERR;
        end
    end

    generate
        if (WR_TIMEOUT > 0) begin : g_wr_timer
            localparam int TIMER_WID = $clog2(WR_TIMEOUT + 1);
            logic [TIMER_WID-1:0] wr_timer;

            always_ff @(posedge clk) begin
                if (srst || !wr_pending)
                    wr_timer <= '0;
                else
                    wr_timer <= wr_timer + 1'b1;
            end
            assign wr_timeout = wr_pending && (wr_timer == TIMER_WID'(WR_TIMEOUT - 1));
        end else begin : g_no_wr_timer
            assign wr_timeout = 1'b0;
        end
    endgenerate

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst)
            arvalid <= 1'b0;
        else if (rd)
            arvalid <= 1'b1;
        else if (axi_rsp.arready)
            arvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd) araddr <= rd_addr;
    end

    assign rready  = rd_pending || (rd_stale != '0);
    assign r_hs    = rready && axi_rsp.rvalid;
    assign r_live  = r_hs && (rd_stale == '0);
    assign rd_done = rd_pending && (r_live || rd_timeout);

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_pending <= 1'b0;
            rd_stale   <= '0;
            rd_ack     <= 1'b0;
            rd_resp    <= RESP_OKAY;
        end else begin
            rd_ack <= rd_done;
            if (rd)
                rd_pending <= 1'b1;
            else if (rd_done)
                rd_pending <= 1'b0;
            rd_stale <= rd_stale + STALE_WID'(rd_timeout && !r_live)
                                 - STALE_WID'(r_hs && (rd_stale != '0));
            if (rd_done)
                rd_resp <= r_live ? axi_rsp.rresp : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done) rd_data <= r_live ? axi_rsp.rdata : `AXI4L_BAD_ACCESS_DATA;
    end

    generate
        if (RD_TIMEOUT > 0) begin : g_rd_timer
            localparam int TIMER_WID = $clog2(RD_TIMEOUT + 1);
            logic [TIMER_WID-1:0] rd_timer;

            always_ff @(posedge clk) begin
                if (srst || !rd_pending)
                    rd_timer <= '0;
                else
                    rd_timer <= rd_timer + 1'b1;
            end
            assign rd_timeout = rd_pending && (rd_timer == TIMER_WID'(RD_TIMEOUT - 1));
        end else begin : g_no_rd_timer
            assign rd_timeout = 1'b0;
        end
    endgenerate

    always_comb begin
        axi_req.awvalid = awvalid;
        axi_req.awaddr  = awaddr;
        axi_req.wvalid  = wvalid;
        axi_req.wdata   = wdata;
        axi_req.wstrb   = wstrb;
        axi_req.bready  = bready;
        axi_req.arvalid = arvalid;
        axi_req.araddr  = araddr;
        axi_req.rready  = rready;
    end

    // Host side has no back-pressure
    assert property (@(posedge clk) disable iff (srst) wr |-> !wr_pending)
        else $error("write strobe while a write is outstanding");
    assert property (@(posedge clk) disable iff (srst) rd |-> !rd_pending)
        else $error("read strobe while a read is outstanding");

endmodule : axi4l_controller

// File: logic/axi4l_params.svh
`ifndef AXI4L_PARAMS_SVH
`define AXI4L_PARAMS_SVH

// Bus geometry
`define AXI4L_ADDR_WID 32
`define AXI4L_DATA_WID 32
`define AXI4L_STRB_WID 4

// Default controller timeouts in clock cycles
`define AXI4L_WR_TIMEOUT 16
`define AXI4L_RD_TIMEOUT 16

// Scratch window sits at the bottom of the map
`define AXI4L_NUM_SCRATCH 6

// Returned to the host when a read never completes
`define AXI4L_BAD_ACCESS_DATA 32'hDEADBEEF

// Read-only identification word
`define AXI4L_ID_VALUE 32'hA4100001

`endif

// File: logic/axi4l_pkg.sv
`include "axi4l_params.svh"

package axi4l_pkg;

    // --------------------------------------------------
    // Response codes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // --------------------------------------------------
    // Channel bundles
    // --------------------------------------------------
    // Master to target bundle of 105 bits
    typedef struct packed {
        logic                       awvalid;
        logic [`AXI4L_ADDR_WID-1:0] awaddr;
        logic                       wvalid;
        logic [`AXI4L_DATA_WID-1:0] wdata;
        logic [`AXI4L_STRB_WID-1:0] wstrb;
        logic                       bready;
        logic                       arvalid;
        logic [`AXI4L_ADDR_WID-1:0] araddr;
        logic                       rready;
    } axi4l_req_t;

    // Target to master bundle of 41 bits
    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic                       bvalid;
        resp_t                      bresp;
        logic                       arready;
        logic                       rvalid;
        resp_t                      rresp;
        logic [`AXI4L_DATA_WID-1:0] rdata;
    } axi4l_rsp_t;

    // --------------------------------------------------
    // Address map helpers
    // --------------------------------------------------
    // First byte address past the scratch registers
    localparam logic [`AXI4L_ADDR_WID-1:0] SCRATCH_END =
        `AXI4L_ADDR_WID'(`AXI4L_NUM_SCRATCH * 4);

    // Low address bits fall inside the same word, so a byte compare is enough
    function automatic logic is_scratch(input logic [`AXI4L_ADDR_WID-1:0] addr);
        return addr < SCRATCH_END;
    endfunction

endpackage : axi4l_pkg

// File: logic/axi4l_reg_file.sv
`include "axi4l_params.svh"

module axi4l_reg_file (
    input  logic                       clk,
    input  logic                       srst,
    input  logic                       reg_wr_en,
    input  logic [`AXI4L_ADDR_WID-1:0] reg_wr_addr,
    input  logic [`AXI4L_DATA_WID-1:0] reg_wr_data,
    input  logic [`AXI4L_STRB_WID-1:0] reg_wr_strb,
    input  logic                       reg_rd_en,
    input  logic [`AXI4L_ADDR_WID-1:0] reg_rd_addr,
    output logic [`AXI4L_DATA_WID-1:0] rd_value,
    output axi4l_pkg::resp_t           wr_result,
    output axi4l_pkg::resp_t           rd_result,
    output logic [7:0]                 wait_states
);
    import axi4l_pkg::*;

    localparam int IDX_WID = $clog2(`AXI4L_NUM_SCRATCH);
    localparam logic [`AXI4L_ADDR_WID-1:0] WAIT_ADDR = 'h18;
    localparam logic [`AXI4L_ADDR_WID-1:0] ID_ADDR   = 'h1C;

    logic [`AXI4L_DATA_WID-1:0] scratch [`AXI4L_NUM_SCRATCH];
    logic [`AXI4L_ADDR_WID-1:0] wr_word;
    logic [`AXI4L_ADDR_WID-1:0] rd_word;
    logic [IDX_WID-1:0]         wr_idx;
    logic [IDX_WID-1:0]         rd_idx;

    // Word decode ignores the byte offset
    assign wr_word = {reg_wr_addr[`AXI4L_ADDR_WID-1:2], 2'b00};
    assign rd_word = {reg_rd_addr[`AXI4L_ADDR_WID-1:2], 2'b00};
    assign wr_idx  = reg_wr_addr[IDX_WID+1:2];
    assign rd_idx  = reg_rd_addr[IDX_WID+1:2];

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reg_wr_en && is_scratch(wr_word)) begin
            for (int b = 0; b < `AXI4L_STRB_WID; b++) begin
                if (reg_wr_strb[b]) scratch[wr_idx][8*b +: 8] <= reg_wr_data[8*b +: 8];
            end
        end
    end

    // Only byte lane 0 is implemented
    always_ff @(posedge clk) begin
        if (srst)
            wait_states <= '0;
        else if (reg_wr_en && wr_word == WAIT_ADDR && reg_wr_strb[0])
            wait_states <= reg_wr_data[7:0];
    end

    // --------------------------------------------------
    // Responses
    // --------------------------------------------------
    always_comb begin
        if (is_scratch(wr_word) || wr_word == WAIT_ADDR) wr_result = RESP_OKAY;
        else if (wr_word == ID_ADDR)                     wr_result = RESP_SLVERR;
        else                                             wr_result = RESP_DECERR;
    end

    always_comb begin
        rd_value  = '0;
        rd_result = RESP_DECERR;
        if (reg_rd_en) begin
            rd_result = RESP_OKAY;
            if (is_scratch(rd_word))    rd_value = scratch[rd_idx];
            else if (rd_word == WAIT_ADDR) rd_value = `AXI4L_DATA_WID'(wait_states);
            else if (rd_word == ID_ADDR)   rd_value = `AXI4L_ID_VALUE;
            else                           rd_result = RESP_DECERR;
        end
    end

endmodule : axi4l_reg_file

// File: logic/axi4l_reg_subsys.sv
`include "axi4l_params.svh"

module axi4l_reg_subsys (
    input  logic                       clk,
    input  logic                       srst,
    input  logic                       wr,
    input  logic [`AXI4L_ADDR_WID-1:0] wr_addr,
    input  logic [`AXI4L_DATA_WID-1:0] wr_data,
    input  logic [`AXI4L_STRB_WID-1:0] wr_strb,
    output logic                       wr_ack,
    output axi4l_pkg::resp_t           wr_resp,
    input  logic                       rd,
    input  logic [`AXI4L_ADDR_WID-1:0] rd_addr,
    output logic [`AXI4L_DATA_WID-1:0] rd_data,
    output logic                       rd_ack,
    output axi4l_pkg::resp_t           rd_resp
);
    import axi4l_pkg::*;

    axi4l_req_t                 axi_req;
    axi4l_rsp_t                 axi_rsp;
    logic                       reg_wr_en;
    logic [`AXI4L_ADDR_WID-1:0] reg_wr_addr;
    logic [`AXI4L_DATA_WID-1:0] reg_wr_data;
    logic [`AXI4L_STRB_WID-1:0] reg_wr_strb;
    logic                       reg_rd_en;
    logic [`AXI4L_ADDR_WID-1:0] reg_rd_addr;
    logic [`AXI4L_DATA_WID-1:0] rd_value;
    resp_t                      wr_result;
    resp_t                      rd_result;
    logic [7:0]                 wait_states;

    // Host strobes to AXI4-Lite
    axi4l_controller ctrl_i (
        .clk, .srst,
        .wr, .wr_addr, .wr_data, .wr_strb, .wr_ack, .wr_resp,
        .rd, .rd_addr, .rd_data, .rd_ack, .rd_resp,
        .axi_req, .axi_rsp
    );

    axi4l_reg_target target_i (
        .clk, .srst, .axi_req, .axi_rsp,
        .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_wr_strb,
        .reg_rd_en, .reg_rd_addr,
        .rd_value, .wr_result, .rd_result, .wait_states
    );

    axi4l_reg_file regs_i (
        .clk, .srst,
        .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_wr_strb,
        .reg_rd_en, .reg_rd_addr,
        .rd_value, .wr_result, .rd_result, .wait_states
    );

endmodule : axi4l_reg_subsys

// File: logic/axi4l_reg_target.sv
`include "axi4l_params.svh"

module axi4l_reg_target (
    input  logic                       clk,
    input  logic                       srst,
    input  axi4l_pkg::axi4l_req_t      axi_req,
    output axi4l_pkg::axi4l_rsp_t      axi_rsp,
    output logic                       reg_wr_en,
    output logic [`AXI4L_ADDR_WID-1:0] reg_wr_addr,
    output logic [`AXI4L_DATA_WID-1:0] reg_wr_data,
    output logic [`AXI4L_STRB_WID-1:0] reg_wr_strb,
    output logic                       reg_rd_en,
    output logic [`AXI4L_ADDR_WID-1:0] reg_rd_addr,
    input  logic [`AXI4L_DATA_WID-1:0] rd_value,
    input  axi4l_pkg::resp_t           wr_result,
    input  axi4l_pkg::resp_t           rd_result,
    input  logic [7:0]                 wait_states
);
    import axi4l_pkg::*;

    logic                       in_service;
    logic                       aw_full;
    logic                       w_full;
    logic [`AXI4L_ADDR_WID-1:0] aw_addr;
    logic [`AXI4L_DATA_WID-1:0] w_data;
    logic [`AXI4L_STRB_WID-1:0] w_strb;
    logic                       wr_issue;
    logic                       wr_busy;
    logic                       wr_scratch;
    logic [7:0]                 wr_cnt;
    logic                       bvalid;
    resp_t                      bresp;
    logic                       rd_issue;
    logic                       rd_busy;
    logic                       rd_scratch;
    logic [7:0]                 rd_cnt;
    logic                       rvalid;
    resp_t                      rresp;
    logic [`AXI4L_DATA_WID-1:0] rdata;

    // Ready outputs stay low until the cycle after reset
    always_ff @(posedge clk) begin
        if (srst) in_service <= 1'b0;
        else      in_service <= 1'b1;
    end

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
        end else begin
            if (axi_req.awvalid && axi_rsp.awready) aw_full <= 1'b1;
            else if (wr_issue)                      aw_full <= 1'b0;
            if (axi_req.wvalid && axi_rsp.wready)   w_full  <= 1'b1;
            else if (wr_issue)                      w_full  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (axi_req.awvalid && axi_rsp.awready) aw_addr <= axi_req.awaddr;
        if (axi_req.wvalid && axi_rsp.wready) begin
            w_data <= axi_req.wdata;
            w_strb <= axi_req.wstrb;
        end
    end

    // One write in the response stage at a time
    assign wr_issue    = aw_full && w_full && !wr_busy;
    assign reg_wr_en   = wr_issue;
    assign reg_wr_addr = aw_addr;
    assign reg_wr_data = w_data;
    assign reg_wr_strb = w_strb;

    // Wait count follows the live register, so lowering it releases a stalled reply
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_busy <= 1'b0;
            wr_cnt  <= '0;
            bvalid  <= 1'b0;
        end else if (wr_issue) begin
            wr_busy <= 1'b1;
            wr_cnt  <= '0;
        end else if (wr_busy && !bvalid) begin
            if (!wr_scratch || wr_cnt >= wait_states) bvalid <= 1'b1;
            else                                      wr_cnt <= wr_cnt + 1'b1;
        end else if (bvalid && axi_req.bready) begin
            bvalid  <= 1'b0;
            wr_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_issue) begin
            bresp      <= wr_result;
            wr_scratch <= is_scratch(aw_addr);
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    // AR goes straight to the register file when the read stage is free
    assign rd_issue    = axi_req.arvalid && axi_rsp.arready;
    assign reg_rd_en   = rd_issue;
    assign reg_rd_addr = axi_req.araddr;

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rvalid  <= 1'b0;
        end else if (rd_issue) begin
            rd_busy <= 1'b1;
            rd_cnt  <= '0;
        end else if (rd_busy && !rvalid) begin
            if (!rd_scratch || rd_cnt >= wait_states) rvalid <= 1'b1;
            else                                      rd_cnt <= rd_cnt + 1'b1;
        end else if (rvalid && axi_req.rready) begin
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rdata      <= rd_value;
            rresp      <= rd_result;
            rd_scratch <= is_scratch(axi_req.araddr);
        end
    end

    always_comb begin
        axi_rsp.awready = in_service && !aw_full;
        axi_rsp.wready  = in_service && !w_full;
        axi_rsp.bvalid  = bvalid;
        axi_rsp.bresp   = bresp;
        axi_rsp.arready = in_service && !rd_busy;
        axi_rsp.rvalid  = rvalid;
        axi_rsp.rresp   = rresp;
        axi_rsp.rdata   = rdata;
    end

    // A response, once offered, holds until the master takes it
    assert property (@(posedge clk) disable iff (srst)
        axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid && $stable(axi_rsp.bresp))
        else $error("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (srst)
        axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata))
        else $error("rvalid dropped before rready");

endmodule : axi4l_reg_target

// File: test/axi4l_golden.txt
# name op addr wdata wstrb resp rdata, numbers in hex
# op W writes wdata under wstrb, op R reads and checks rdata

# Byte strobes on the scratch window
scr0_fill     W 00       11223344 f OKAY   00000000
scr0_lanes02  W 00       aabbccdd 5 OKAY   00000000
scr0_check    R 00       00000000 0 OKAY   11bb33dd
scr5_fill     W 14       cafef00d f OKAY   00000000
scr5_upper    W 16       12345678 c OKAY   00000000
scr5_check    R 14       00000000 0 OKAY   1234f00d
scr3_fill     W 0c       0badc0de f OKAY   00000000
scr3_lane1    W 0c       00005500 2 OKAY   00000000
scr3_check    R 0c       00000000 0 OKAY   0bad55de
ws_reset_val  R 18       00000000 0 OKAY   00000000

# Outside the map
unmap_rd_lo   R 20       00000000 0 DECERR 00000000
unmap_rd_hi   R 00001000 00000000 0 DECERR 00000000
unmap_wr_lo   W 24       ffffffff f DECERR 00000000
unmap_wr_hi   W 80000000 ffffffff f DECERR 00000000

# Identification word is read only
id_wr         W 1c       12345678 f SLVERR 00000000
id_rd         R 1c       00000000 0 OKAY   a4100001
id_rd_offset  R 1e       00000000 0 OKAY   a4100001

# Five wait states, under the timeout
ws5_set       W 18       00000005 1 OKAY   00000000
ws5_readback  R 18       00000000 0 OKAY   00000005
ws5_scr2_wr   W 08       5a5aa5a5 f OKAY   00000000
ws5_scr2_rd   R 08       00000000 0 OKAY   5a5aa5a5
ws5_scr0_rd   R 00       00000000 0 OKAY   11bb33dd
ws5_id_rd     R 1c       00000000 0 OKAY   a4100001

# Forty wait states, scratch accesses time out
ws40_set      W 18       00000028 1 OKAY   00000000
ws40_scr1_wr  W 04       76543210 f SLVERR 00000000
ws40_scr2_rd  R 08       00000000 0 SLVERR deadbeef

# Recovery, the timed-out write still reached scratch 1
rcv_ws_clear  W 18       00000000 1 OKAY   00000000
rcv_scr1_rd   R 04       00000000 0 OKAY   76543210
rcv_scr2_rd   R 08       00000000 0 OKAY   5a5aa5a5
rcv_ws_rd     R 18       00000000 0 OKAY   00000000
rcv_scr4_wr   W 10       13579bdf f OKAY   00000000
rcv_scr4_rd   R 10       00000000 0 OKAY   13579bdf

// File: test/tb_axi4l_reg_subsys.sv
`include "axi4l_params.svh"

module tb_axi4l_reg_subsys;
    import axi4l_pkg::*;

    // Longest wait for any acknowledge is well above both controller timeouts
    localparam int ACK_LIMIT = 100;

    logic                       clk;
    logic                       srst;
    logic                       wr;
    logic [`AXI4L_ADDR_WID-1:0] wr_addr;
    logic [`AXI4L_DATA_WID-1:0] wr_data;
    logic [`AXI4L_STRB_WID-1:0] wr_strb;
    logic                       wr_ack;
    resp_t                      wr_resp;
    logic                       rd;
    logic [`AXI4L_ADDR_WID-1:0] rd_addr;
    logic [`AXI4L_DATA_WID-1:0] rd_data;
    logic                       rd_ack;
    resp_t                      rd_resp;
    int                         vec_count;

    axi4l_reg_subsys dut_i (
        .clk, .srst,
        .wr, .wr_addr, .wr_data, .wr_strb, .wr_ack, .wr_resp,
        .rd, .rd_addr, .rd_data, .rd_ack, .rd_resp
    );

    always #2 clk = ~clk;

    // --------------------------------------------------
    // Failure handling and result checks
    // --------------------------------------------------
    task automatic end_in_failure();
        $display("sim failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_resp(input string test, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            $display("ERROR %s: response expected %s (%b), actual %s (%b)",
                     test, exp.name(), exp, act.name(), act);
            end_in_failure();
        end
    endtask

    task automatic check_data(input string test,
                              input logic [`AXI4L_DATA_WID-1:0] exp,
                              input logic [`AXI4L_DATA_WID-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: read data expected %h, actual %h", test, exp, act);
            end_in_failure();
        end
    endtask

    // Response names as written in the vector file
    task automatic decode_resp(input string name, output resp_t code, output bit ok);
        ok   = 1'b1;
        code = RESP_OKAY;
        if (name == "OKAY")        code = RESP_OKAY;
        else if (name == "EXOKAY") code = RESP_EXOKAY;
        else if (name == "SLVERR") code = RESP_SLVERR;
        else if (name == "DECERR") code = RESP_DECERR;
        else                       ok = 1'b0;
    endtask

    // --------------------------------------------------
    // Host port accesses
    // --------------------------------------------------
    // The idle direction must stay quiet, so a drained late response shows up here
    task automatic wait_ack(input string test, input bit is_read);
        int cyc;
        bit seen;
        bit other;
        seen = 1'b0;
        for (cyc = 0; cyc < ACK_LIMIT && !seen; cyc++) begin
            @(posedge clk);
            #1;
            seen  = is_read ? rd_ack : wr_ack;
            other = is_read ? wr_ack : rd_ack;
            if (other) begin
                $display("Test %s: unexpected acknowledge on the idle %s port",
                         test, is_read ? "write" : "read");
                end_in_failure();
            end
        end
        if (!seen) begin
            $display("Test %s: no acknowledge within %0d cycles", test, ACK_LIMIT);
            end_in_failure();
        end
    endtask

    task automatic write_word(input string test,
                              input logic [`AXI4L_ADDR_WID-1:0] addr,
                              input logic [`AXI4L_DATA_WID-1:0] data,
                              input logic [`AXI4L_STRB_WID-1:0] strb,
                              input resp_t exp_resp);
        wr      = 1'b1;
        wr_addr = addr;
        wr_data = data;
        wr_strb = strb;
        @(posedge clk);
        #1;
        wr = 1'b0;
        wait_ack(test, 1'b0);
        check_resp(test, exp_resp, wr_resp);
    endtask

    task automatic read_word(input string test,
                             input logic [`AXI4L_ADDR_WID-1:0] addr,
                             input resp_t exp_resp,
                             input logic [`AXI4L_DATA_WID-1:0] exp_data);
        rd      = 1'b1;
        rd_addr = addr;
        @(posedge clk);
        #1;
        rd = 1'b0;
        wait_ack(test, 1'b1);
        check_resp(test, exp_resp, rd_resp);
        check_data(test, exp_data, rd_data);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin : run
        int                         fd;
        int                         n;
        string                      line;
        string                      name;
        string                      op;
        string                      resp_name;
        logic [`AXI4L_ADDR_WID-1:0] addr;
        logic [`AXI4L_DATA_WID-1:0] data;
        logic [`AXI4L_STRB_WID-1:0] strb;
        logic [`AXI4L_DATA_WID-1:0] exp_data;
        resp_t                      exp_resp;
        bit                         resp_ok;

        clk       = 1'b0;
        srst      = 1'b1;
        wr        = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        wr_strb   = '0;
        rd        = 1'b0;
        rd_addr   = '0;
        vec_count = 0;

        repeat (5) @(posedge clk);
        #1;
        srst = 1'b0;

        fd = $fopen("test/axi4l_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file test/axi4l_golden.txt");
            end_in_failure();
        end

        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %s %h",
                            name, op, addr, data, strb, resp_name, exp_data);
                if (n >= 1 && n != 7) begin
                    $display("Malformed vector line: %s", line);
                    end_in_failure();
                end else if (n == 7) begin
                    decode_resp(resp_name, exp_resp, resp_ok);
                    if (!resp_ok) begin
                        $display("Test %s: unknown response name %s", name, resp_name);
                        end_in_failure();
                    end
                    if (op == "W") begin
                        write_word(name, addr, data, strb, exp_resp);
                    end else if (op == "R") begin
                        read_word(name, addr, exp_resp, exp_data);
                    end else begin
                        $display("Test %s: unknown operation %s", name, op);
                        end_in_failure();
                    end
                    vec_count++;
                end
            end
        end
        $fclose(fd);

        if (vec_count == 0) begin
            $display("The vector file held no accesses");
            end_in_failure();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule : tb_axi4l_reg_subsys

// File: vlog.f
+incdir+logic
logic/axi4l_pkg.sv
logic/axi4l_controller.sv
logic/axi4l_reg_file.sv
logic/axi4l_reg_target.sv
logic/axi4l_reg_subsys.sv
test/tb_axi4l_reg_subsys.sv
